// File: list.f
+incdir+.
axi_lite_pkg.sv
demo_regs_pkg.sv
axi_lite_crossbar.sv
ocm_ram.sv
image_path_regs.sv
mt9v034_demo.sv
tb_mt9v034_demo.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_mt9v034_demo \
  -f list.f -o tb_mt9v034_demo_sim &&
./obj_dir/tb_mt9v034_demo_sim ||
{ echo "simulation did not complete successfully"; exit 1; }

// File: tb_mt9v034_demo.sv
// Directed testbench for the camera demo top, acting as the AXI-lite master
`timescale 1ns/10ps

`include "mt9v034_settings.svh"

module tb_mt9v034_demo;

  import axi_lite_pkg::*;
  import demo_regs_pkg::*;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 10;
  localparam int LED_TRIES    = 4;
  localparam int SW_TRIES     = 4;
  localparam int MEM_WORDS    = 32;
  localparam int BP_TRIES     = 3;
  // Transactions issued over the whole run
  localparam int NUM_TXN = 1 + 2 * LED_TRIES + SW_TRIES + 3 + 6 + 2 * MEM_WORDS + 3
                           + 3 * BP_TRIES;

  logic          aclk;
  logic          rst_n_i;
  axi_lite_req_t req;
  axi_lite_rsp_t rsp;
  logic [7:0]    sws;
  logic [7:0]    leds;
  integer        seed;

  logic [31:0]   model [`OCM_DEPTH];  // Expected memory words
  bit            known [`OCM_DEPTH];  // Word holds a defined value

  mt9v034_demo UUT (
    .aclk( aclk),
    .rst_n_i( rst_n_i),
    .axi_req_i( req),
    .axi_rsp_o( rsp),
    .sws_i( sws),
    .leds_o( leds)
  );

  always #(CLK_PERIOD / 2) aclk = ~aclk;

  // ----------------------------------------------------------
  // Checking and failure
  // ----------------------------------------------------------
  task automatic stop_run();
    $display(">>> FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      $display("mismatch at %0t ns: %s expected %h actual %h", $time, name, exp, got);
      stop_run();
    end
  endtask

  // Byte lanes picked by a strobe mask
  function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  // Register window alias, bits 11..4 don't care
  function automatic logic [31:0] reg_addr(input logic [3:0] offset);
    logic [31:0] rnd;
    rnd = $random(seed);
    return {20'd0, rnd[11:4], offset};
  endfunction

  // ----------------------------------------------------------
  // AXI-lite master
  // ----------------------------------------------------------
  // Drive on the falling edge, sample 1 ns later while stable
  task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input int hold, output axi_resp_e resp);
    @(negedge aclk);
    req.aw_valid = 1'b1;
    req.aw_addr  = addr;
    req.w_valid  = 1'b1;
    req.w_data   = data;
    req.w_strb   = strb;
    req.b_ready  = 1'b0;
    #1;
    while (!(rsp.aw_ready && rsp.w_ready)) begin
      @(negedge aclk);
      #1;
    end
    @(negedge aclk);                 // Beat moved on the last rising edge
    req.aw_valid = 1'b0;
    req.w_valid  = 1'b0;
    #1;
    while (!rsp.b_valid) begin
      @(negedge aclk);
      #1;
    end
    repeat (hold) begin              // Response held off by the master
      @(negedge aclk);
      req.aw_valid = 1'b1;           // Next beat offered, must wait for B
      req.w_valid  = 1'b1;
      #1;
      check_value("b_valid", 32'd1, 32'(rsp.b_valid));
      check_value("aw_ready", 32'd0, 32'(rsp.aw_ready));
    end
    @(negedge aclk);
    req.aw_valid = 1'b0;
    req.w_valid  = 1'b0;
    req.b_ready  = 1'b1;
    #1;
    check_value("b_valid", 32'd1, 32'(rsp.b_valid));
    resp = rsp.b_resp;
    @(negedge aclk);
    req.b_ready = 1'b0;
  endtask

  task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
                          output axi_resp_e resp);
    @(negedge aclk);
    req.ar_valid = 1'b1;
    req.ar_addr  = addr;
    req.r_ready  = 1'b0;
    #1;
    while (!rsp.ar_ready) begin
      @(negedge aclk);
      #1;
    end
    @(negedge aclk);
    req.ar_valid = 1'b0;
    #1;
    while (!rsp.r_valid) begin
      @(negedge aclk);
      #1;
    end
    @(negedge aclk);
    req.r_ready = 1'b1;
    #1;
    check_value("r_valid", 32'd1, 32'(rsp.r_valid));
    data = rsp.r_data;
    resp = rsp.r_resp;
    @(negedge aclk);
    req.r_ready = 1'b0;
  endtask

  // ----------------------------------------------------------
  // Tests
  // ----------------------------------------------------------
  task automatic reset_state_test();
    logic [31:0] rdata;
    axi_resp_e   resp;
    check_value("leds_o", 32'd0, 32'(leds));
    axi_read(reg_addr(REG_ID), rdata, resp);
    check_value("r_resp", 32'(RESP_OKAY), 32'(resp));
    check_value("r_data", `SENSOR_ID, rdata);
  endtask

  task automatic register_test();
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic [31:0] old_word;
    logic [31:0] rnd;
    axi_resp_e   resp;
    repeat (LED_TRIES) begin
      wdata = $random(seed);
      axi_write(reg_addr(REG_LED), wdata, 4'hF, 0, resp);
      check_value("b_resp", 32'(RESP_OKAY), 32'(resp));
      check_value("leds_o", {24'd0, wdata[7:0]}, 32'(leds));
      axi_read(reg_addr(REG_LED), rdata, resp);
      check_value("r_resp", 32'(RESP_OKAY), 32'(resp));
      check_value("r_data", {24'd0, wdata[7:0]}, rdata);  // Zeros above the LED byte
    end
    repeat (SW_TRIES) begin
      rnd = $random(seed);
      @(negedge aclk);
      sws = rnd[7:0];
      axi_read(reg_addr(REG_SWITCH), rdata, resp);
      check_value("r_resp", 32'(RESP_OKAY), 32'(resp));
      check_value("r_data", {24'd0, rnd[7:0]}, rdata);
    end
    // Scratch, full word then a strobed overwrite
    old_word = $random(seed);
    axi_write(reg_addr(REG_SCRATCH), old_word, 4'hF, 0, resp);
    check_value("b_resp", 32'(RESP_OKAY), 32'(resp));
    wdata = $random(seed);
    rnd   = $random(seed);
    axi_write(reg_addr(REG_SCRATCH), wdata, rnd[3:0], 0, resp);
    check_value("b_resp", 32'(RESP_OKAY), 32'(resp));
    axi_read(reg_addr(REG_SCRATCH), rdata, resp);
    check_value("r_resp", 32'(RESP_OKAY), 32'(resp));
    check_value("r_data", merge_lanes(old_word, wdata, rnd[3:0]), rdata);
  endtask

  task automatic register_error_test();
    logic [31:0] rdata;
    logic [31:0] rnd;
    logic [7:0]  led_before;
    axi_resp_e   resp;
    rnd = $random(seed);
    axi_write(reg_addr(REG_ID), rnd, 4'hF, 0, resp);
    check_value("b_resp", 32'(RESP_SLVERR), 32'(resp));
    axi_read(reg_addr(REG_ID), rdata, resp);
    check_value("r_resp", 32'(RESP_OKAY), 32'(resp));
    check_value("r_data", `SENSOR_ID, rdata);            // Identity untouched
    axi_write(reg_addr(REG_SWITCH), ~{24'd0, sws}, 4'hF, 0, resp);
    check_value("b_resp", 32'(RESP_SLVERR), 32'(resp));
    axi_read(reg_addr(REG_SWITCH), rdata, resp);
    check_value("r_resp", 32'(RESP_OKAY), 32'(resp));
    check_value("r_data", {24'd0, sws}, rdata);
    // Offsets off the word grid
    led_before = leds;
    axi_write(reg_addr(4'h5), rnd, 4'hF, 0, resp);
    check_value("b_resp", 32'(RESP_SLVERR), 32'(resp));
    check_value("leds_o", 32'(led_before), 32'(leds));
    axi_read(reg_addr(4'hA), rdata, resp);
    check_value("r_resp", 32'(RESP_SLVERR), 32'(resp));
  endtask

  task automatic memory_test();
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic [31:0] rnd;
    logic [3:0]  strb;
    int          idx;
    int          written[$];
    axi_resp_e   resp;
    for (int n = 0; n < MEM_WORDS; n++) begin
      rnd   = $random(seed);
      idx   = int'(rnd[5:0]) % `OCM_DEPTH;
      strb  = known[idx] ? rnd[15:12] : 4'hF;   // First write defines the whole word
      wdata = $random(seed);
      // Bits 11..8 alias onto the same word
      addr  = (32'd1 << `SLAVE_SEL_BIT) | (32'(rnd[11:8]) << 8) | (32'(idx) << 2);
      axi_write(addr, wdata, strb, 0, resp);
      check_value("b_resp", 32'(RESP_OKAY), 32'(resp));
      model[idx] = merge_lanes(model[idx], wdata, strb);
      known[idx] = 1'b1;
      written.push_back(idx);
    end
    foreach (written[k]) begin
      rnd  = $random(seed);
      addr = (32'd1 << `SLAVE_SEL_BIT) | (32'(rnd[11:8]) << 8) | (32'(written[k]) << 2);
      axi_read(addr, rdata, resp);
      check_value("r_resp", 32'(RESP_OKAY), 32'(resp));
      check_value("r_data", model[written[k]], rdata);
    end
  endtask

  task automatic decode_error_test();
    logic [31:0] rdata;
    axi_resp_e   resp;
    axi_read(32'h0000_2000, rdata, resp);    // Bit 13 set
    check_value("r_resp", 32'(RESP_DECERR), 32'(resp));
    axi_write(32'h8000_1000, 32'hDEAD_BEEF, 4'hF, 0, resp);
    check_value("b_resp", 32'(RESP_DECERR), 32'(resp));
    axi_read(reg_addr(REG_ID), rdata, resp);  // Map still alive
    check_value("r_resp", 32'(RESP_OKAY), 32'(resp));
    check_value("r_data", `SENSOR_ID, rdata);
  endtask

  task automatic backpressure_test();
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic [31:0] rnd;
    int          hold;
    axi_resp_e   resp;
    repeat (BP_TRIES) begin
      rnd   = $random(seed);
      hold  = 1 + int'(rnd[3:0]);
      wdata = $random(seed);
      axi_write(reg_addr(REG_SCRATCH), wdata, 4'hF, hold, resp);
      check_value("b_resp", 32'(RESP_OKAY), 32'(resp));
      rnd  = $random(seed);
      hold = 1 + int'(rnd[3:0]);
      axi_write(reg_addr(REG_ID), rnd, 4'hF, hold, resp);  // Error code held too
      check_value("b_resp", 32'(RESP_SLVERR), 32'(resp));
      axi_read(reg_addr(REG_SCRATCH), rdata, resp);
      check_value("r_resp", 32'(RESP_OKAY), 32'(resp));
      check_value("r_data", wdata, rdata);
    end
  endtask

  // ----------------------------------------------------------
  // Run control
  // ----------------------------------------------------------
  initial begin : watchdog
    #(CLK_PERIOD * (RESET_CYCLES + 200 * NUM_TXN));
    $display("timeout: the DUT did not finish %0d transactions in time", NUM_TXN);
    stop_run();
  end

  initial begin
    seed    = 32'h31ef_02d3;
    aclk    = 1'b0;
    rst_n_i = 1'b0;
    req     = '0;
    sws     = 8'h00;
    foreach (known[i]) begin
      known[i] = 1'b0;
    end
    repeat (RESET_CYCLES) @(posedge aclk);
    @(negedge aclk);
    rst_n_i = 1'b1;
    reset_state_test();
    register_test();
    register_error_test();
    memory_test();
    decode_error_test();
    backpressure_test();
    $display(">>> PASS");
    $finish;
  end

endmodule

// File: mt9v034_demo.sv
// Camera demo programmable-logic top joining the AXI-lite crossbar, control registers and memory
`timescale 1ns/10ps

module mt9v034_demo (
  input  logic                        aclk,
  input  logic                        rst_n_i,
  // General-purpose AXI-lite master port
  input  axi_lite_pkg::axi_lite_req_t axi_req_i,
  output axi_lite_pkg::axi_lite_rsp_t axi_rsp_o,
  // Board I/O
  input  logic [7:0]                  sws_i,
  output logic [7:0]                  leds_o
);

  import axi_lite_pkg::*;

  // ----------------------------------------------------------
  // Crossbar to slave links
  // ----------------------------------------------------------
  axi_lite_req_t regs_req;    // Port 0
  axi_lite_rsp_t regs_rsp;
  axi_lite_req_t ocm_req;     // Port 1
  axi_lite_rsp_t ocm_rsp;

  // Address bit 12 picks the slave
  axi_lite_crossbar axi_lite_crossbar_inst (
    .aclk( aclk),
    .rst_n_i( rst_n_i),
    .s_req_i( axi_req_i),
    .s_rsp_o( axi_rsp_o),
    .regs_req_o( regs_req),
    .regs_rsp_i( regs_rsp),
    .ocm_req_o( ocm_req),
    .ocm_rsp_i( ocm_rsp)
  );

  // Control registers, owner of switches and LEDs
  image_path_regs image_path_regs_inst (
    .aclk( aclk),
    .rst_n_i( rst_n_i),
    .req_i( regs_req),
    .rsp_o( regs_rsp),
    .sws_i( sws_i),
    .leds_o( leds_o)
  );

  // On-chip memory
  ocm_ram ocm_ram_inst (
    .aclk( aclk),
    .rst_n_i( rst_n_i),
    .req_i( ocm_req),
    .rsp_o( ocm_rsp)
  );

endmodule

// File: image_path_regs.sv
// Image-path control registers holding sensor identity, LEDs, switch sample and scratch word
`timescale 1ns/10ps

`include "mt9v034_settings.svh"

module image_path_regs (
  input  logic                        aclk,
  input  logic                        rst_n_i,
  input  axi_lite_pkg::axi_lite_req_t req_i,
  output axi_lite_pkg::axi_lite_rsp_t rsp_o,
  input  logic [7:0]                  sws_i,   // Board switches
  output logic [7:0]                  leds_o   // Board LEDs
);

  import axi_lite_pkg::*;
  import demo_regs_pkg::*;

  reg_offset_e            wr_off;
  reg_offset_e            rd_off;
  logic                   wr_fire;
  logic                   rd_fire;
  logic                   b_valid_q;
  axi_resp_e              b_resp_q;
  logic                   r_valid_q;
  axi_resp_e              r_resp_q;
  logic [`AXI_DATA_W-1:0] r_data_q;
  led_bits_t              led_q;       // LED register
  logic [`AXI_DATA_W-1:0] scratch_q;   // Scratch register

  // Only the low nibble decodes, window repeats every 16 bytes
  assign wr_off = reg_offset_e'(req_i.aw_addr[3:0]);
  assign rd_off = reg_offset_e'(req_i.ar_addr[3:0]);

  assign wr_fire = req_i.aw_valid && req_i.w_valid && !b_valid_q;
  assign rd_fire = req_i.ar_valid && !r_valid_q;

  // ----------------------------------------------------------
  // Write side
  // ----------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!rst_n_i) begin
      b_valid_q <= 1'B0;
      b_resp_q  <= RESP_OKAY;
      led_q     <= '0;                 // LEDs dark out of reset
      scratch_q <= '0;
    end else if (wr_fire) begin
      b_valid_q <= 1'B1;
      b_resp_q  <= RESP_OKAY;
      case (wr_off)
        REG_LED: begin
          if (req_i.w_strb[0]) begin
            led_q <= req_i.w_data[7:0];  // Only lane 0 backed
          end
        end
        REG_SCRATCH: begin
          scratch_q <= apply_strb(scratch_q, req_i.w_data, req_i.w_strb);
        end
        // Read-only registers and misaligned offsets
        default: begin
          b_resp_q <= RESP_SLVERR;
        end
      endcase
    end else if (req_i.b_ready) begin
      b_valid_q <= 1'B0;
    end
  end

  // ----------------------------------------------------------
  // Read side
  // ----------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!rst_n_i) begin
      r_valid_q <= 1'B0;
    end else if (rd_fire) begin
      r_valid_q <= 1'B1;
    end else if (req_i.r_ready) begin
      r_valid_q <= 1'B0;
    end
  end

  // Read word and status latched at acceptance
  always_ff @(posedge aclk) begin
    if (rd_fire) begin
      r_resp_q <= RESP_OKAY;
      case (rd_off)
        REG_ID:      r_data_q <= `SENSOR_ID;
        REG_LED:     r_data_q <= {24'H0, led_q};
        REG_SWITCH:  r_data_q <= {24'H0, sws_i};   // Switch sample
        REG_SCRATCH: r_data_q <= scratch_q;
        default: begin
          r_data_q <= '0;                           // Not word aligned
          r_resp_q <= RESP_SLVERR;
        end
      endcase
    end
  end

  always_comb begin
    rsp_o.aw_ready = wr_fire;
    rsp_o.w_ready  = wr_fire;
    rsp_o.b_valid  = b_valid_q;
    rsp_o.b_resp   = b_resp_q;
    rsp_o.ar_ready = rd_fire;
    rsp_o.r_valid  = r_valid_q;
    rsp_o.r_data   = r_data_q;
    rsp_o.r_resp   = r_resp_q;
  end

  assign leds_o = led_q;

endmodule

// File: ocm_ram.sv
// On-chip memory slave, 32-bit words behind AXI-lite with byte strobes
`timescale 1ns/10ps

`include "mt9v034_settings.svh"

module ocm_ram (
  input  logic                        aclk,
  input  logic                        rst_n_i,
  input  axi_lite_pkg::axi_lite_req_t req_i,
  output axi_lite_pkg::axi_lite_rsp_t rsp_o
);

  import axi_lite_pkg::*;

  localparam int IDX_W = $clog2(`OCM_DEPTH);  // Word index width

  logic [`AXI_DATA_W-1:0] mem [`OCM_DEPTH];

  logic [IDX_W-1:0]       wr_idx;
  logic [IDX_W-1:0]       rd_idx;
  logic                   wr_fire;
  logic                   rd_fire;
  logic                   b_valid_q;  // Write response pending
  logic                   r_valid_q;  // Read response pending
  logic [`AXI_DATA_W-1:0] r_data_q;

  // ----------------------------------------------------------
  // Address phase
  // ----------------------------------------------------------
  // Word index from bits above the byte lanes, upper bits wrap
  assign wr_idx = req_i.aw_addr[IDX_W+1:2];
  assign rd_idx = req_i.ar_addr[IDX_W+1:2];

  // Address and data taken together, never with a B still out
  assign wr_fire = req_i.aw_valid && req_i.w_valid && !b_valid_q;
  assign rd_fire = req_i.ar_valid && !r_valid_q;

  // Storage
  always_ff @(posedge aclk) begin
    if (wr_fire) begin
      mem[wr_idx] <= apply_strb(mem[wr_idx], req_i.w_data, req_i.w_strb);
    end
  end

  // Read data captured at acceptance
  always_ff @(posedge aclk) begin
    if (rd_fire) begin
      r_data_q <= mem[rd_idx];
    end
  end

  // ----------------------------------------------------------
  // Response valids
  // ----------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!rst_n_i) begin
      b_valid_q <= 1'B0;
    end else if (wr_fire) begin
      b_valid_q <= 1'B1;          // Up the cycle after acceptance
    end else if (req_i.b_ready) begin
      b_valid_q <= 1'B0;          // Held until taken
    end
  end

  always_ff @(posedge aclk) begin
    if (!rst_n_i) begin
      r_valid_q <= 1'B0;
    end else if (rd_fire) begin
      r_valid_q <= 1'B1;
    end else if (req_i.r_ready) begin
      r_valid_q <= 1'B0;
    end
  end

  // Slave side of the bus
  always_comb begin
    rsp_o.aw_ready = wr_fire;     // Same-cycle accept
    rsp_o.w_ready  = wr_fire;
    rsp_o.b_valid  = b_valid_q;
    rsp_o.b_resp   = RESP_OKAY;   // Memory never faults
    rsp_o.ar_ready = rd_fire;
    rsp_o.r_valid  = r_valid_q;
    rsp_o.r_data   = r_data_q;
    rsp_o.r_resp   = RESP_OKAY;
  end

endmodule

// File: axi_lite_crossbar.sv
// AXI-lite crossbar steering one master to the control registers or the on-chip memory
`timescale 1ns/10ps

`include "mt9v034_settings.svh"

module axi_lite_crossbar (
  input  logic                        aclk,
  input  logic                        rst_n_i,
  // Upstream master
  input  axi_lite_pkg::axi_lite_req_t s_req_i,
  output axi_lite_pkg::axi_lite_rsp_t s_rsp_o,
  // Port 0, control registers
  output axi_lite_pkg::axi_lite_req_t regs_req_o,
  input  axi_lite_pkg::axi_lite_rsp_t regs_rsp_i,
  // Port 1, on-chip memory
  output axi_lite_pkg::axi_lite_req_t ocm_req_o,
  input  axi_lite_pkg::axi_lite_rsp_t ocm_rsp_i
);

  import axi_lite_pkg::*;

  typedef enum logic [1:0] {
    IDLE,      // Decoding the next address
    ROUTE,     // Waiting on the latched slave
    OWN_RESP   // Local DECERR pending
  } xbar_state_e;

  xbar_state_e wr_state;
  xbar_state_e rd_state;
  logic        wr_sel_q;  // Latched slave, 1 = memory
  logic        rd_sel_q;

  logic aw_hole;          // Write address not mapped
  logic ar_hole;
  logic aw_sel;
  logic ar_sel;
  logic wr_open;          // Mapped write may pass
  logic rd_open;
  logic aw_fire;
  logic ar_fire;
  logic b_fire;
  logic r_fire;

  // ----------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------
  assign aw_hole = |s_req_i.aw_addr[`AXI_ADDR_W-1:`MAP_TOP_BIT+1];
  assign ar_hole = |s_req_i.ar_addr[`AXI_ADDR_W-1:`MAP_TOP_BIT+1];
  assign aw_sel  = s_req_i.aw_addr[`SLAVE_SEL_BIT];
  assign ar_sel  = s_req_i.ar_addr[`SLAVE_SEL_BIT];

  assign wr_open = (wr_state == IDLE) && !aw_hole;
  assign rd_open = (rd_state == IDLE) && !ar_hole;

  // Upstream handshakes
  assign aw_fire = s_req_i.aw_valid && s_rsp_o.aw_ready;
  assign ar_fire = s_req_i.ar_valid && s_rsp_o.ar_ready;
  assign b_fire  = s_rsp_o.b_valid && s_req_i.b_ready;
  assign r_fire  = s_rsp_o.r_valid && s_req_i.r_ready;

  // Request steering
  always_comb begin
    regs_req_o = s_req_i;   // Payload fanned out to both slaves
    ocm_req_o  = s_req_i;
    regs_req_o.aw_valid = s_req_i.aw_valid && wr_open && !aw_sel;
    regs_req_o.w_valid  = s_req_i.w_valid  && wr_open && !aw_sel;
    ocm_req_o.aw_valid  = s_req_i.aw_valid && wr_open && aw_sel;
    ocm_req_o.w_valid   = s_req_i.w_valid  && wr_open && aw_sel;
    regs_req_o.ar_valid = s_req_i.ar_valid && rd_open && !ar_sel;
    ocm_req_o.ar_valid  = s_req_i.ar_valid && rd_open && ar_sel;
    // Response ready only toward the owner of the transfer
    regs_req_o.b_ready  = s_req_i.b_ready && (wr_state == ROUTE) && !wr_sel_q;
    ocm_req_o.b_ready   = s_req_i.b_ready && (wr_state == ROUTE) && wr_sel_q;
    regs_req_o.r_ready  = s_req_i.r_ready && (rd_state == ROUTE) && !rd_sel_q;
    ocm_req_o.r_ready   = s_req_i.r_ready && (rd_state == ROUTE) && rd_sel_q;
  end

  // ----------------------------------------------------------
  // Upstream response mux
  // ----------------------------------------------------------
  always_comb begin
    s_rsp_o = '0;
    case (wr_state)
      IDLE: begin
        if (aw_hole) begin
          // Hole, swallow address and data together
          s_rsp_o.aw_ready = s_req_i.aw_valid && s_req_i.w_valid;
          s_rsp_o.w_ready  = s_req_i.aw_valid && s_req_i.w_valid;
        end else begin
          s_rsp_o.aw_ready = aw_sel ? ocm_rsp_i.aw_ready : regs_rsp_i.aw_ready;
          s_rsp_o.w_ready  = aw_sel ? ocm_rsp_i.w_ready  : regs_rsp_i.w_ready;
        end
      end
      ROUTE: begin
        s_rsp_o.b_valid = wr_sel_q ? ocm_rsp_i.b_valid : regs_rsp_i.b_valid;
        s_rsp_o.b_resp  = wr_sel_q ? ocm_rsp_i.b_resp  : regs_rsp_i.b_resp;
      end
      OWN_RESP: begin
        s_rsp_o.b_valid = 1'B1;
        s_rsp_o.b_resp  = RESP_DECERR;
      end
      default: ;
    endcase
    case (rd_state)
      IDLE: begin
        s_rsp_o.ar_ready = ar_hole ? s_req_i.ar_valid
                                   : (ar_sel ? ocm_rsp_i.ar_ready : regs_rsp_i.ar_ready);
      end
      ROUTE: begin
        s_rsp_o.r_valid = rd_sel_q ? ocm_rsp_i.r_valid : regs_rsp_i.r_valid;
        s_rsp_o.r_data  = rd_sel_q ? ocm_rsp_i.r_data  : regs_rsp_i.r_data;
        s_rsp_o.r_resp  = rd_sel_q ? ocm_rsp_i.r_resp  : regs_rsp_i.r_resp;
      end
      OWN_RESP: begin
        s_rsp_o.r_valid = 1'B1;   // Data stays zero
        s_rsp_o.r_resp  = RESP_DECERR;
      end
      default: ;
    endcase
  end

  // Write direction FSM
  always_ff @(posedge aclk) begin
    if (!rst_n_i) begin
      wr_state <= IDLE;
      wr_sel_q <= 1'B0;
    end else begin
      case (wr_state)
        IDLE: begin
          if (aw_fire) begin
            wr_sel_q <= aw_sel;                         // Lock choice until B
            wr_state <= aw_hole ? OWN_RESP : ROUTE;
          end
        end
        default: begin
          if (b_fire) begin
            wr_state <= IDLE;
          end
        end
      endcase
    end
  end

  // Read direction FSM, independent of writes
  always_ff @(posedge aclk) begin
    if (!rst_n_i) begin
      rd_state <= IDLE;
      rd_sel_q <= 1'B0;
    end else begin
      case (rd_state)
        IDLE: begin
          if (ar_fire) begin
            rd_sel_q <= ar_sel;
            rd_state <= ar_hole ? OWN_RESP : ROUTE;
          end
        end
        default: begin
          if (r_fire) begin
            rd_state <= IDLE;
          end
        end
      endcase
    end
  end

endmodule

// File: demo_regs_pkg.sv
// Register map of the image-path control block
package demo_regs_pkg;

  // ----------------------------------------------------------
  // Byte offsets inside the 16-byte register window
  // ----------------------------------------------------------
  typedef enum logic [3:0] {
    REG_ID      = 4'H0,  // Sensor identity, read-only
    REG_LED     = 4'H4,  // LED byte in bits 7..0
    REG_SWITCH  = 4'H8,  // Switch sample, read-only
    REG_SCRATCH = 4'HC   // Free 32-bit word for software
  } reg_offset_e;

  // LED field of REG_LED
  // Bit n drives LED n, upper 24 bits read as zero
  typedef logic [7:0] led_bits_t;

endpackage

// File: axi_lite_pkg.sv
// AXI-lite bus types shared by the crossbar and its slaves
`include "mt9v034_settings.svh"

package axi_lite_pkg;

  // Response codes as on the wire
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'B00,
    RESP_SLVERR = 2'B10,  // Slave saw a bad access
    RESP_DECERR = 2'B11   // Nobody lives at this address
  } axi_resp_e;

  // Master-driven side, 105 bits
  typedef struct packed {
    logic                   aw_valid;
    logic [`AXI_ADDR_W-1:0] aw_addr;
    logic                   w_valid;
    logic [`AXI_DATA_W-1:0] w_data;
    logic [`AXI_STRB_W-1:0] w_strb;
    logic                   b_ready;
    logic                   ar_valid;
    logic [`AXI_ADDR_W-1:0] ar_addr;
    logic                   r_ready;
  } axi_lite_req_t;

  // Slave-driven side, 41 bits
  typedef struct packed {
    logic                   aw_ready;
    logic                   w_ready;
    logic                   b_valid;
    axi_resp_e              b_resp;
    logic                   ar_ready;
    logic                   r_valid;
    logic [`AXI_DATA_W-1:0] r_data;
    axi_resp_e              r_resp;
  } axi_lite_rsp_t;

  // Byte-lane merge of a write beat into an old word
  function automatic logic [`AXI_DATA_W-1:0] apply_strb(
      input logic [`AXI_DATA_W-1:0] old_word,
      input logic [`AXI_DATA_W-1:0] new_word,
      input logic [`AXI_STRB_W-1:0] strb);
    logic [`AXI_DATA_W-1:0] merged;
    merged = old_word;
    for (int i = 0; i < `AXI_STRB_W; i++) begin
      if (strb[i]) begin
        merged[8*i +: 8] = new_word[8*i +: 8];  // Lane enabled
      end
    end
    return merged;
  endfunction

endpackage

// File: mt9v034_settings.svh
// Camera demo settings covering AXI-lite bus geometry, address map, memory size and sensor identity
`ifndef MT9V034_SETTINGS_SVH
`define MT9V034_SETTINGS_SVH

// ----------------------------------------------------------
// AXI-lite bus geometry
// ----------------------------------------------------------
`define AXI_ADDR_W     32
`define AXI_DATA_W     32
`define AXI_STRB_W     4            // One strobe per byte lane

// ----------------------------------------------------------
// Address map
// ----------------------------------------------------------
`define SLAVE_SEL_BIT  12           // 0 = control registers, 1 = on-chip memory
`define MAP_TOP_BIT    12           // Any set bit above this is a hole

// On-chip memory size in 32-bit words
`define OCM_DEPTH      64

// MT9V034 chip version as seen by software
`define SENSOR_ID      32'H0000_1324

`endif
